// ==== branch_resolve.f ====
+incdir+src
src/branch_pkg.sv
src/branch_issue_queue.sv
src/btb_predictor.sv
src/fu_branch.sv
src/branch_resolve_top.sv
verif/branch_resolve_chk.sv
verif/branch_resolve_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := branch_resolve_tb
FILELIST := branch_resolve.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/branch_stimulus.txt ====
// opcode pc imm reg_a reg_b outcome correct_pc, all hex, opcode is funct3
// (0 beq, 1 bne, 4 blt, 5 bge, 6 bltu, 7 bgeu), an opcode of ff ends the list
// each opcode once, with signed and unsigned edge values
0 00000100 00000020 00000005 00000005 1 00000120
1 00000104 fffffff0 00000005 00000005 0 00000108
4 00000108 00000040 80000000 00000001 1 00000148
6 0000010c 00000040 80000000 00000001 0 00000110
5 00000110 00000010 7fffffff 80000000 1 00000120
7 00000114 00000010 7fffffff 80000000 0 00000118
5 00000118 ffffff00 ffffffff ffffffff 1 00000018
6 0000011c 00000008 00000000 ffffffff 1 00000124
// one loop branch learned up to a saturated counter
1 00000200 00000080 00000001 00000002 1 00000280
1 00000200 00000080 00000001 00000002 1 00000280
1 00000200 00000080 00000001 00000002 1 00000280
1 00000200 00000080 00000001 00000002 1 00000280
// loop exit, then taken again
1 00000200 00000080 00000002 00000002 0 00000204
1 00000200 00000080 00000001 00000002 1 00000280
// 0x600 shares row 0 with 0x200 and 0x100
0 00000600 00000100 00000003 00000003 1 00000700
1 00000200 00000080 00000001 00000002 1 00000280
0 00000600 00000100 00000003 00000004 0 00000604
4 00000300 fffffffc fffffffe ffffffff 1 000002fc
6 00000304 00000020 fffffffe ffffffff 1 00000324
5 00000308 00000020 00000001 ffffffff 1 00000328
ff 0 0 0 0 0 0

// ==== verif/branch_resolve_tb.sv ====
`timescale 1ns/1ps
`include "branch_defines.svh"

module branch_resolve_tb;
  import branch_pkg::*;

  localparam int COLS = 7;
  localparam int MAX_OPS = 32;

  typedef struct packed {
    br_result_t res;
    word_t      pc;
  } pending_t;

  logic       CLK;
  logic       nRST;
  logic       issue_valid;
  br_op_t     issue_op;
  logic       issue_credit;
  logic       res_credit;
  logic       res_valid;
  br_result_t res;

  logic [31:0] stim [COLS*MAX_OPS];
  pending_t    exp_q [$];

  // reference BTB, one row per pc[5:2]
  logic             ref_valid [`BTB_ENTRIES];
  logic [`WORD_W-7:0] ref_tag [`BTB_ENTRIES];
  word_t            ref_target [`BTB_ENTRIES];
  logic [1:0]       ref_ctr [`BTB_ENTRIES];

  int          n_ops;
  int          sent;
  int          checked;
  int          errors;
  int          credits;
  int          owed;
  int          returned;
  int          cycle;
  int          seed;
  logic [31:0] rnd;
  logic        op_ok;

  branch_resolve_top DUT (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_credit (issue_credit),
    .res_credit   (res_credit),
    .res_valid    (res_valid),
    .res          (res)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic compare_value(input string name, input word_t got, input word_t exp);
    assert (got == exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errors++;
      op_ok = 1'b0;
    end
  endtask

  task automatic update_model(input word_t pc, input logic taken, input word_t target);
    logic [3:0] idx;
    logic       hit;
    idx = pc[5:2];
    hit = ref_valid[idx] && (ref_tag[idx] == pc[31:6]);
    if (taken && !hit) begin
      ref_valid[idx]  = 1'b1;
      ref_tag[idx]    = pc[31:6];
      ref_target[idx] = target;
      ref_ctr[idx]    = 2'd2;
    end else if (taken) begin
      ref_target[idx] = target;
      if (ref_ctr[idx] != 2'd3) ref_ctr[idx] = ref_ctr[idx] + 2'd1;
    end else if (hit && ref_ctr[idx] != 2'd0) begin
      ref_ctr[idx] = ref_ctr[idx] - 2'd1;
    end
  endtask

  // builds op i from the data file and predicts it the way the BTB would now
  task automatic send_op(input int i);
    pending_t   p;
    logic [3:0] idx;
    logic       p_taken;
    word_t      p_target;
    word_t      pc;
    logic       taken;
    pc = stim[i*COLS+1];
    taken = stim[i*COLS+5][0];
    issue_op.tag         = i[3:0];
    issue_op.branch_type = branch_type_e'(stim[i*COLS][2:0]);
    issue_op.current_pc  = pc;
    issue_op.imm         = stim[i*COLS+2];
    issue_op.reg_a       = stim[i*COLS+3];
    issue_op.reg_b       = stim[i*COLS+4];
    idx = pc[5:2];
    p_taken = ref_valid[idx] && (ref_tag[idx] == pc[31:6]) && ref_ctr[idx][1];
    p_target = p_taken ? ref_target[idx] : pc + 32'd4;
    p.pc = pc;
    p.res.tag = i[3:0];
    p.res.branch_outcome = taken;
    p.res.branch_target = pc + stim[i*COLS+2];
    p.res.miss = (taken != p_taken) || (taken && p_target != p.res.branch_target);
    p.res.correct_pc = stim[i*COLS+6];
    exp_q.push_back(p);
    issue_valid = 1'b1;
    credits--;
    sent++;
  endtask

  task automatic check_result();
    pending_t p;
    if (exp_q.size() == 0) begin
      $display("result with tag %h arrived with no op outstanding", res.tag);
      errors++;
    end else begin
      p = exp_q.pop_front();
      op_ok = 1'b1;
      compare_value("res.tag", word_t'(res.tag), word_t'(p.res.tag));
      compare_value("res.branch_outcome", word_t'(res.branch_outcome),
                    word_t'(p.res.branch_outcome));
      compare_value("res.miss", word_t'(res.miss), word_t'(p.res.miss));
      compare_value("res.correct_pc", res.correct_pc, p.res.correct_pc);
      compare_value("res.branch_target", res.branch_target, p.res.branch_target);
      $display("op %0d tag %h pc %h miss %b: %s", checked, p.res.tag, p.pc,
               p.res.miss, op_ok ? "ok" : "mismatch");
      update_model(p.pc, p.res.branch_outcome, p.res.branch_target);
      checked++;
      owed++;
    end
  endtask

  initial begin
    nRST = 1'b0;
    issue_valid = 1'b0;
    issue_op = '0;
    res_credit = 1'b0;
    seed = 32'hd0add6c0;
    {sent, checked, errors, owed, returned, cycle} = '0;
    credits = `IQ_DEPTH;
    foreach (ref_valid[k]) ref_valid[k] = 1'b0;
    $readmemh("verif/branch_stimulus.txt", stim);
    n_ops = 0;
    while (n_ops < MAX_OPS && stim[n_ops*COLS] != 32'hff) n_ops++;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    while (sent < n_ops || exp_q.size() != 0) begin
      @(negedge CLK);
      cycle++;
      if (issue_credit) credits++;
      assert (credits <= `IQ_DEPTH) else begin
        $display("more issue credits returned than ops were sent");
        errors++;
      end
      if (res_valid) begin
        assert (`RES_CREDITS - checked + returned > 0) else begin
          $display("result arrived while the branch unit held no result credit");
          errors++;
        end
        check_result();
      end
      if (res_credit) returned++;
      // result credits are withheld for a while so that the queue fills up
      rnd = $random(seed);
      res_credit = (owed > 0) && (cycle < 8 || cycle > 30) && rnd[0];
      if (res_credit) owed--;
      if (sent < n_ops && credits > 0) send_op(sent);
      else issue_valid = 1'b0;
    end
    res_credit = 1'b0;
    repeat (3) begin
      @(negedge CLK);
      assert (!res_valid) else begin
        $display("extra result after all ops were checked");
        errors++;
      end
    end
    compare_value("issue credits", word_t'(credits), word_t'(`IQ_DEPTH));
    errors += DUT.u_chk.fails;
    $display("%0d of %0d ops checked, %0d errors", checked, n_ops, errors);
    if (errors == 0 && checked == n_ops) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (n_ops * 60) @(posedge CLK);
    $display("watchdog expired with %0d of %0d ops checked", checked, n_ops);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verif/branch_resolve_chk.sv ====
`timescale 1ns/1ps
`include "branch_defines.svh"

module branch_resolve_chk (
  input logic              CLK,
  input logic              nRST,
  input logic              issue_valid,
  input logic              issue_credit,
  input logic              head_pop,
  input logic              res_credit,
  input logic              res_valid,
  input logic              btb_upd_valid,
  input branch_pkg::tag_t  head_tag
);
  int occupancy;
  int held;
  int fails;

  // queue fill and result credits, followed from the handshakes alone
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      occupancy <= 0;
      held      <= `RES_CREDITS;
    end else begin
      occupancy <= occupancy + ((issue_valid && occupancy < `IQ_DEPTH) ? 1 : 0)
                   - (head_pop ? 1 : 0);
      held      <= held - (head_pop ? 1 : 0) + (res_credit ? 1 : 0);
    end
  end

  initial fails = 0;

  no_write_when_full: assert property (@(posedge CLK) disable iff (!nRST)
    issue_valid |-> occupancy < `IQ_DEPTH)
    else begin
      $error("issue queue written while full");
      fails++;
    end

  one_update_per_tag: assert property (@(posedge CLK) disable iff (!nRST)
    btb_upd_valid |=> !btb_upd_valid || head_tag != $past(head_tag))
    else begin
      $error("second BTB update for tag %h", head_tag);
      fails++;
    end

  // held is sampled one edge earlier, when the result was resolved
  result_needs_credit: assert property (@(posedge CLK) disable iff (!nRST)
    res_valid |-> $past(held) > 0)
    else begin
      $error("result sent without a held result credit");
      fails++;
    end

  quiet_in_reset: assert property (@(posedge CLK)
    !nRST |-> !issue_credit && !head_pop && !res_valid && !btb_upd_valid)
    else begin
      $error("control output high during reset");
      fails++;
    end

endmodule

bind branch_resolve_top branch_resolve_chk u_chk (
  .CLK           (CLK),
  .nRST          (nRST),
  .issue_valid   (issue_valid),
  .issue_credit  (issue_credit),
  .head_pop      (head_pop),
  .res_credit    (res_credit),
  .res_valid     (res_valid),
  .btb_upd_valid (btb_upd_valid),
  .head_tag      (head_entry.op.tag)
);

// ==== src/branch_resolve_top.sv ====
`timescale 1ns/1ps

module branch_resolve_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   issue_valid,
  input  branch_pkg::br_op_t     issue_op,
  output logic                   issue_credit,
  input  logic                   res_credit,
  output logic                   res_valid,
  output branch_pkg::br_result_t res
);
  import branch_pkg::*;

  logic        pred_taken;
  word_t       pred_target;
  br_entry_t   wr_entry;
  logic        head_valid;
  br_entry_t   head_entry;
  logic        head_pop;
  logic        btb_upd_valid;
  btb_update_t btb_upd;

  // the prediction is taken from the BTB in the cycle the op is accepted
  assign wr_entry.op                = issue_op;
  assign wr_entry.predicted_outcome = pred_taken;
  assign wr_entry.predicted_target  = pred_target;

  branch_issue_queue u_queue (
    .CLK          (CLK),
    .nRST         (nRST),
    .wr_valid     (issue_valid),
    .wr_entry     (wr_entry),
    .head_valid   (head_valid),
    .head_entry   (head_entry),
    .head_pop     (head_pop),
    .issue_credit (issue_credit)
  );

  btb_predictor u_btb (
    .CLK         (CLK),
    .nRST        (nRST),
    .lookup_pc   (issue_op.current_pc),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .upd_valid   (btb_upd_valid),
    .upd         (btb_upd)
  );

  fu_branch u_fu (
    .CLK           (CLK),
    .nRST          (nRST),
    .head_valid    (head_valid),
    .head_entry    (head_entry),
    .head_pop      (head_pop),
    .res_credit    (res_credit),
    .res_valid     (res_valid),
    .res           (res),
    .btb_upd_valid (btb_upd_valid),
    .btb_upd       (btb_upd)
  );

endmodule

// ==== src/fu_branch.sv ====
`timescale 1ns/1ps
`include "branch_defines.svh"

module fu_branch (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    head_valid,
  input  branch_pkg::br_entry_t   head_entry,
  output logic                    head_pop,
  input  logic                    res_credit,
  output logic                    res_valid,
  output branch_pkg::br_result_t  res,
  output logic                    btb_upd_valid,
  output branch_pkg::btb_update_t btb_upd
);
  import branch_pkg::*;

  localparam int CW = $clog2(`RES_CREDITS + 1);

  logic [CW-1:0] credit_cnt;
  logic          credit_avail;
  logic          resolve;

  logic  is_eq;
  logic  is_lt;
  logic  is_ltu;
  logic  actual_outcome;
  logic  miss;
  word_t taken_pc;
  word_t fall_pc;

  // guards against a second BTB write for an op presented twice
  logic btb_updated;
  tag_t last_tag;
  logic upd_blocked;

  assign is_eq  = (head_entry.op.reg_a == head_entry.op.reg_b);
  assign is_lt  = ($signed(head_entry.op.reg_a) < $signed(head_entry.op.reg_b));
  assign is_ltu = (head_entry.op.reg_a < head_entry.op.reg_b);

  always_comb begin
    case (head_entry.op.branch_type)
      BT_BEQ:  actual_outcome = is_eq;
      BT_BNE:  actual_outcome = !is_eq;
      BT_BLT:  actual_outcome = is_lt;
      BT_BGE:  actual_outcome = !is_lt;
      BT_BLTU: actual_outcome = is_ltu;
      BT_BGEU: actual_outcome = !is_ltu;
      default: actual_outcome = 1'b0;
    endcase
  end

  assign taken_pc = head_entry.op.current_pc + head_entry.op.imm;
  assign fall_pc  = head_entry.op.current_pc + word_t'(4);

  // a taken branch with the right direction but a stale target is still a miss
  assign miss = (actual_outcome != head_entry.predicted_outcome) ||
                (actual_outcome && (head_entry.predicted_target != taken_pc));

  assign credit_avail = (credit_cnt != '0);
  assign resolve      = head_valid && credit_avail;
  assign head_pop     = resolve;

  assign upd_blocked   = btb_updated && (last_tag == head_entry.op.tag);
  assign btb_upd_valid = resolve && !upd_blocked;

  assign btb_upd.update_pc     = head_entry.op.current_pc;
  assign btb_upd.taken         = actual_outcome;
  assign btb_upd.branch_target = taken_pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      credit_cnt  <= CW'(`RES_CREDITS);
      res_valid   <= 1'b0;
      btb_updated <= 1'b0;
      last_tag    <= '0;
    end else begin
      case ({resolve, res_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      res_valid <= resolve;
      if (btb_upd_valid) begin
        btb_updated <= 1'b1;
        last_tag    <= head_entry.op.tag;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resolve) begin
      res.tag            <= head_entry.op.tag;
      res.branch_outcome <= actual_outcome;
      res.miss           <= miss;
      res.correct_pc     <= actual_outcome ? taken_pc : fall_pc;
      res.branch_target  <= taken_pc;
    end
  end

endmodule

// ==== src/btb_predictor.sv ====
`timescale 1ns/1ps
`include "branch_defines.svh"

module btb_predictor (
  input  logic                    CLK,
  input  logic                    nRST,
  input  branch_pkg::word_t       lookup_pc,
  output logic                    pred_taken,
  output branch_pkg::word_t       pred_target,
  input  logic                    upd_valid,
  input  branch_pkg::btb_update_t upd
);
  import branch_pkg::*;

  localparam int IDX_W = $clog2(`BTB_ENTRIES);
  localparam int TAG_HI_W = `WORD_W - IDX_W - 2;

  logic [`BTB_ENTRIES-1:0] valid;
  logic [TAG_HI_W-1:0]     tag_mem [`BTB_ENTRIES];
  word_t                   target_mem [`BTB_ENTRIES];
  logic [1:0]              ctr_mem [`BTB_ENTRIES];

  logic [IDX_W-1:0]    lk_idx;
  logic [TAG_HI_W-1:0] lk_tag;
  logic                lk_hit;

  logic [IDX_W-1:0]    up_idx;
  logic [TAG_HI_W-1:0] up_tag;
  logic                up_hit;

  // the low two PC bits are always zero for aligned instructions
  assign lk_idx = lookup_pc[IDX_W+1:2];
  assign lk_tag = lookup_pc[`WORD_W-1:IDX_W+2];
  assign lk_hit = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);

  // counter values 2 and 3 predict taken
  assign pred_taken  = lk_hit && ctr_mem[lk_idx][1];
  assign pred_target = pred_taken ? target_mem[lk_idx] : lookup_pc + word_t'(4);

  assign up_idx = upd.update_pc[IDX_W+1:2];
  assign up_tag = upd.update_pc[`WORD_W-1:IDX_W+2];
  assign up_hit = valid[up_idx] && (tag_mem[up_idx] == up_tag);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (upd_valid && upd.taken && !up_hit) begin
      valid[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (upd_valid) begin
      if (upd.taken) begin
        target_mem[up_idx] <= upd.branch_target;
        if (up_hit) begin
          if (ctr_mem[up_idx] != 2'd3) begin
            ctr_mem[up_idx] <= ctr_mem[up_idx] + 2'd1;
          end
        end else begin
          // allocation evicts whatever row aliased here and starts weakly taken
          tag_mem[up_idx] <= up_tag;
          ctr_mem[up_idx] <= 2'd2;
        end
      end else if (up_hit && ctr_mem[up_idx] != 2'd0) begin
        ctr_mem[up_idx] <= ctr_mem[up_idx] - 2'd1;
      end
    end
  end

endmodule

// ==== src/branch_issue_queue.sv ====
`timescale 1ns/1ps
`include "branch_defines.svh"

module branch_issue_queue (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  wr_valid,
  input  branch_pkg::br_entry_t wr_entry,
  output logic                  head_valid,
  output branch_pkg::br_entry_t head_entry,
  input  logic                  head_pop,
  output logic                  issue_credit
);
  import branch_pkg::*;

  localparam int PTR_W = $clog2(`IQ_DEPTH);
  localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

  br_entry_t mem [`IQ_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == CNT_W'(`IQ_DEPTH));
  assign head_valid = (count != '0);
  assign head_entry = mem[rd_ptr];

  // a write into a full queue is dropped here and flagged by the checker
  assign push = wr_valid && !full;
  assign pop  = head_pop && head_valid;

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rd_ptr       <= '0;
      wr_ptr       <= '0;
      count        <= '0;
      issue_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // every popped entry frees one slot for the dispatcher
      issue_credit <= pop;
    end
  end

endmodule

// ==== src/branch_pkg.sv ====
`include "branch_defines.svh"

package branch_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`TAG_W-1:0] tag_t;

  // opcodes follow the RV32 funct3 encoding of the conditional branches
  typedef enum logic [2:0] {
    BT_BEQ  = 3'b000,
    BT_BNE  = 3'b001,
    BT_BLT  = 3'b100,
    BT_BGE  = 3'b101,
    BT_BLTU = 3'b110,
    BT_BGEU = 3'b111
  } branch_type_e;

  typedef struct packed {
    tag_t         tag;
    branch_type_e branch_type;
    word_t        current_pc;
    word_t        imm;
    word_t        reg_a;
    word_t        reg_b;
  } br_op_t;

  // an op as it waits in the queue, with the prediction made at dispatch
  typedef struct packed {
    br_op_t op;
    logic   predicted_outcome;
    word_t  predicted_target;
  } br_entry_t;

  typedef struct packed {
    tag_t  tag;
    logic  branch_outcome;
    logic  miss;
    word_t correct_pc;
    word_t branch_target;
  } br_result_t;

  typedef struct packed {
    word_t update_pc;
    logic  taken;
    word_t branch_target;
  } btb_update_t;

endpackage

// ==== src/branch_defines.svh ====
`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// data path and PC width
`define WORD_W 32

// number of rows in the direct-mapped BTB
// the row index comes from pc[5:2]
`define BTB_ENTRIES 16

// issue queue depth, also the dispatcher's starting issue credits
`define IQ_DEPTH 4

// result credits the branch unit holds toward the reorder buffer
`define RES_CREDITS 2

// width of the op sequence tag
`define TAG_W 4

`endif
